// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_i2c_master
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only -Wall --timing
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// File: dv/i2c_checker.sv
module i2c_checker (
    input logic clock,
    input logic reset_n,
    input logic req,
    input logic ack,
    input logic scl_low,
    input logic sda_low,
    input logic scl_in,
    input logic sda_in
);
    int violations = 0;

    // SDA falls under a high SCL only for a master START
    start_edge: assert property (@(posedge clock) disable iff (!reset_n)
        (scl_in && $past(scl_in) && $fell(sda_in)) |-> $rose(sda_low))
    else begin
        violations++;
        $error("SDA fell with SCL high without a START from the master");
    end

    // and rises under a high SCL only for STOP
    stop_edge: assert property (@(posedge clock) disable iff (!reset_n)
        (scl_in && $past(scl_in) && $rose(sda_in)) |-> $fell(sda_low))
    else begin
        violations++;
        $error("SDA rose with SCL high without a STOP from the master");
    end

    // req as seen on the clock that raised ack
    ack_needs_req: assert property (@(posedge clock) disable iff (!reset_n)
        $rose(ack) |-> $past(req))
    else begin
        violations++;
        $error("ack rose while req was low");
    end

    bus_released: assert property (@(posedge clock) disable iff (!reset_n)
        ack |-> (!scl_low && !sda_low))
    else begin
        violations++;
        $error("bus line still pulled low while ack is high");
    end

endmodule

bind i2c_master i2c_checker bus_checks (
    .clock   (clock),
    .reset_n (reset_n),
    .req     (req),
    .ack     (ack),
    .scl_low (scl_low),
    .sda_low (sda_low),
    .scl_in  (scl_in),
    .sda_in  (sda_in)
);

// File: dv/i2c_target_model.sv
module i2c_target_model #(
    parameter logic [6:0] address = 7'h2a
) (
    input  logic clock,
    input  logic scl,
    input  logic sda,
    output logic sda_low
);
    typedef enum logic [2:0] {
        listen,
        get_address,
        get_register,
        get_data,
        send_data
    } bus_mode_t;

    logic [7:0] registers [256];
    logic [7:0] shift_in;
    logic [7:0] shift_out;
    logic [7:0] pointer;
    logic [3:0] bit_count;
    logic       read_dir;
    logic       scl_q;
    logic       sda_q;
    bus_mode_t  mode;

    // fill pattern spans the whole register address
    initial begin
        for (int index = 0; index < 256; index++) begin
            registers[index] = 8'(index * 37 + 11);
        end
        mode      = listen;
        sda_low   = 1'b0;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        bit_count = '0;
        pointer   = '0;
        read_dir  = 1'b0;
        shift_in  = '0;
        shift_out = '0;
    end

    //////////////////////////////////////////////////
    // oversampled bus, one step per system clock
    //////////////////////////////////////////////////

    always @(posedge clock) begin
        scl_q <= scl;
        sda_q <= sda;
        if (scl_q && scl && sda_q && !sda) begin
            // START or repeated START, pointer survives
            mode      <= get_address;
            bit_count <= '0;
            sda_low   <= 1'b0;
        end else if (scl_q && scl && !sda_q && sda) begin
            mode    <= listen;
            sda_low <= 1'b0;
        end else if ((mode != listen) && !scl_q && scl) begin
            bit_count <= bit_count + 1'b1;
            if (bit_count < 4'd8) begin
                shift_in <= {shift_in[6:0], sda};
            end
        end else if ((mode != listen) && scl_q && !scl) begin
            if (bit_count == 4'd9) begin
                // acknowledge clock is over
                sda_low   <= 1'b0;
                bit_count <= '0;
                case (mode)
                    get_address: begin
                        if (read_dir) begin
                            mode      <= send_data;
                            shift_out <= registers[pointer];
                            sda_low   <= !registers[pointer][7];
                        end else begin
                            mode <= get_register;
                        end
                    end
                    get_register: mode <= get_data;
                    send_data:    mode <= listen;
                    default:      mode <= mode;
                endcase
            end else if (mode == send_data) begin
                // release for the master's acknowledge after bit 0
                if (bit_count < 4'd8) begin
                    sda_low <= !shift_out[~bit_count[2:0]];
                end else begin
                    sda_low <= 1'b0;
                end
            end else if (bit_count == 4'd8) begin
                case (mode)
                    get_address: begin
                        if (shift_in[7:1] == address) begin
                            sda_low  <= 1'b1;
                            read_dir <= shift_in[0];
                        end else begin
                            mode <= listen;
                        end
                    end
                    get_register: begin
                        pointer <= shift_in;
                        sda_low <= 1'b1;
                    end
                    default: begin
                        registers[pointer] <= shift_in;
                        sda_low            <= 1'b1;
                    end
                endcase
            end
        end
    end

endmodule

// File: dv/tb_i2c_master.sv
module tb_i2c_master;
    import i2c_pkg::*;

    localparam dev_addr_t target_address = 7'h2a;
    localparam int        seed           = 12336;
    localparam int        txn_count      = 120;
    localparam int        max_divider    = 6;
    localparam int        max_hold       = 12;
    localparam int        period         = 40;
    // read is the longest: three sent bytes, restart, read byte, nack and stop
    localparam int        read_quarters  = 160;
    localparam int        txn_cycles     = read_quarters * (max_divider + 1) + max_hold + 8;

    logic      clock;
    logic      reset_n;
    logic      req;
    logic      rw;
    dev_addr_t device_address;
    reg_addr_t register_address;
    data_t     write_data;
    divider_t  divider;
    logic      ack;
    logic      nack;
    data_t     read_data;
    logic      scl_low;
    logic      sda_low;
    logic      target_sda_low;
    logic      scl;
    logic      sda;
    data_t     expected_mem [256];
    int        issued;
    reg_addr_t last_written;

    // open-drain lines with pull-ups
    assign scl = !scl_low;
    assign sda = !(sda_low || target_sda_low);

    i2c_master uut (
        .clock            (clock),
        .reset_n          (reset_n),
        .req              (req),
        .rw               (rw),
        .device_address   (device_address),
        .register_address (register_address),
        .write_data       (write_data),
        .divider          (divider),
        .ack              (ack),
        .nack             (nack),
        .read_data        (read_data),
        .scl_low          (scl_low),
        .sda_low          (sda_low),
        .scl_in           (scl),
        .sda_in           (sda)
    );

    i2c_target_model #(.address(target_address)) target (
        .clock   (clock),
        .scl     (scl),
        .sda     (sda),
        .sda_low (target_sda_low)
    );

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = !clock;
    end

    initial begin
        #((txn_count + 1) * txn_cycles * period + 10 * period);
        $display("%0t: watchdog expired before all transactions finished", $time);
        $display("** FAIL **");
        $fatal(1, "watchdog timeout");
    end

    //////////////////////////////////////////////////
    // error reporting and reference model
    //////////////////////////////////////////////////

    task automatic value_error(input string name, input int expected, input int actual);
        $display("[ERROR] %0t %s expected 0x%0h actual 0x%0h", $time, name, expected, actual);
        $display("** FAIL **");
        $fatal(1, "wrong value on %s", name);
    endtask

    task automatic plain_error(input string what);
        $display("%0t: %s", $time, what);
        $display("** FAIL **");
        $fatal(1, "%s", what);
    endtask

    function automatic data_t initial_fill(input int index);
        return data_t'(index * 37 + 11);
    endfunction

    task automatic compare_target_memory();
        int index;
        for (index = 0; index < 256; index++) begin
            assert (target.registers[index] == expected_mem[index])
            else value_error($sformatf("target.registers[%0d]", index),
                             int'(expected_mem[index]), int'(target.registers[index]));
        end
    endtask

    task automatic run_transaction(input logic is_read, input dev_addr_t dev,
                                   input reg_addr_t reg_index, input data_t data);
        int    waited;
        int    hold;
        int    gap;
        logic  expect_nack;
        data_t expect_data;
        logic  held_nack;
        data_t held_data;
        expect_nack = (dev != target_address);
        expect_data = expected_mem[reg_index];
        // ack stays low while req rests low between requests
        gap = $urandom_range(3, 0);
        repeat (gap) begin
            @(negedge clock);
            assert (!ack) else value_error("ack", 0, int'(ack));
        end
        rw               = is_read;
        device_address   = dev;
        register_address = reg_index;
        write_data       = data;
        divider          = divider_t'($urandom_range(max_divider, 0));
        req              = 1'b1;
        waited           = 0;
        do begin
            @(negedge clock);
            waited++;
            assert (waited <= txn_cycles) else plain_error("no ack within the transaction limit");
        end while (!ack);
        assert (nack == expect_nack) else value_error("nack", int'(expect_nack), int'(nack));
        if (is_read && !expect_nack) begin
            assert (read_data == expect_data)
            else value_error("read_data", int'(expect_data), int'(read_data));
        end
        if (!is_read && !expect_nack) begin
            expected_mem[reg_index] = data;
            last_written            = reg_index;
        end
        // results must hold while req stays high
        held_nack = nack;
        held_data = read_data;
        hold      = $urandom_range(max_hold, 0);
        repeat (hold) begin
            @(negedge clock);
            assert (ack) else plain_error("ack fell while req was still high");
            assert (nack == held_nack) else value_error("nack", int'(held_nack), int'(nack));
            assert (read_data == held_data)
            else value_error("read_data", int'(held_data), int'(read_data));
        end
        req = 1'b0;
        @(negedge clock);
        assert (!ack) else plain_error("ack did not fall one clock after req fell");
        issued++;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        int        kind;
        int        index;
        reg_addr_t reg_index;
        dev_addr_t other;
        void'($urandom(seed));
        reset_n          = 1'b0;
        req              = 1'b0;
        rw               = 1'b0;
        device_address   = '0;
        register_address = '0;
        write_data       = '0;
        divider          = '0;
        issued           = 0;
        last_written     = '0;
        for (index = 0; index < 256; index++) begin
            expected_mem[index] = initial_fill(index);
        end
        repeat (2) @(negedge clock);
        reset_n = 1'b1;

        // idle outputs before the first request
        repeat (3) begin
            @(negedge clock);
            assert (!ack) else value_error("ack", 0, int'(ack));
            assert (!nack) else value_error("nack", 0, int'(nack));
            assert (!scl_low) else value_error("scl_low", 0, int'(scl_low));
            assert (!sda_low) else value_error("sda_low", 0, int'(sda_low));
            assert (read_data == '0) else value_error("read_data", 0, int'(read_data));
        end

        while (issued < txn_count) begin
            kind = $urandom_range(3, 0);
            // low registers half the time so reads hit earlier writes
            if ($urandom_range(1, 0) == 1) begin
                reg_index = reg_addr_t'($urandom_range(15, 0));
            end else begin
                reg_index = reg_addr_t'($urandom);
            end
            case (kind)
                0, 1: run_transaction(1'b0, target_address, reg_index, data_t'($urandom));
                2:    run_transaction(1'b1, target_address, reg_index, '0);
                default: begin
                    other = dev_addr_t'($urandom);
                    if (other == target_address) begin
                        other = other ^ 7'h01;
                    end
                    run_transaction(1'($urandom_range(1, 0)), other, reg_index,
                                    data_t'($urandom));
                    compare_target_memory();
                    run_transaction(1'b1, target_address, last_written, '0);
                end
            endcase
        end

        if (uut.bus_checks.violations != 0) begin
            $display("bus checker flagged %0d rule violations", uut.bus_checks.violations);
            $display("** FAIL **");
            $fatal(1, "bus rule violations");
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// File: source/i2c_byte_shifter.sv
module i2c_byte_shifter (
    input  logic           clock,
    input  logic           reset_n,
    input  logic           load,
    input  i2c_pkg::data_t load_byte,
    input  logic           shift,
    input  logic           sample,
    input  logic           sda_in,
    output logic           out_bit,
    output i2c_pkg::data_t in_byte
);
    import i2c_pkg::*;

    localparam int byte_width = $bits(data_t);

    data_t out_byte;

    //////////////////////////////////////////////////
    // outbound path
    //////////////////////////////////////////////////

    // address, register or write data, MSB first
    always_ff @(posedge clock) begin
        if (load) begin
            out_byte <= load_byte;
        end else if (shift) begin
            out_byte <= {out_byte[byte_width-2:0], 1'b0};
        end
    end

    assign out_bit = out_byte[byte_width-1];

    //////////////////////////////////////////////////
    // inbound path
    //////////////////////////////////////////////////

    // read data arrives MSB first as well
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            in_byte <= '0;
        end else if (sample) begin
            in_byte <= {in_byte[byte_width-2:0], sda_in};
        end
    end

endmodule

// File: source/i2c_config.svh
`ifndef I2C_CONFIG_SVH
`define I2C_CONFIG_SVH

//////////////////////////////////////////////////
// bus field widths
//////////////////////////////////////////////////

// 7-bit addressing only
`define I2C_ADDR_WIDTH 7

// register address and data are one byte each
`define I2C_BYTE_WIDTH 8

// phase length in clock cycles minus one
`define I2C_DIVIDER_WIDTH 16

`define I2C_BITS_PER_BYTE 8

`endif

// File: source/i2c_master.sv
module i2c_master (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               req,
    input  logic               rw,
    input  i2c_pkg::dev_addr_t device_address,
    input  i2c_pkg::reg_addr_t register_address,
    input  i2c_pkg::data_t     write_data,
    input  i2c_pkg::divider_t  divider,
    output logic               ack,
    output logic               nack,
    output i2c_pkg::data_t     read_data,
    output logic               scl_low,
    output logic               sda_low,
    input  logic               scl_in,
    input  logic               sda_in
);
    import i2c_pkg::*;

    logic   timer_enable;
    logic   phase_tick;
    phase_t phase;
    logic   load;
    logic   shift;
    logic   sample;
    data_t  load_byte;
    logic   out_bit;

    //////////////////////////////////////////////////
    // quarter-bit timing
    //////////////////////////////////////////////////

    i2c_phase_timer phase_timer (
        .clock      (clock),
        .reset_n    (reset_n),
        .enable     (timer_enable),
        .divider    (divider),
        .phase_tick (phase_tick),
        .phase      (phase)
    );

    //////////////////////////////////////////////////
    // serial shift path
    //////////////////////////////////////////////////

    // read_data holds after the last sample
    i2c_byte_shifter byte_shifter (
        .clock     (clock),
        .reset_n   (reset_n),
        .load      (load),
        .load_byte (load_byte),
        .shift     (shift),
        .sample    (sample),
        .sda_in    (sda_in),
        .out_bit   (out_bit),
        .in_byte   (read_data)
    );

    i2c_transaction_fsm transaction_fsm (
        .clock            (clock),
        .reset_n          (reset_n),
        .req              (req),
        .rw               (rw),
        .device_address   (device_address),
        .register_address (register_address),
        .write_data       (write_data),
        .phase_tick       (phase_tick),
        .phase            (phase),
        .out_bit          (out_bit),
        .sda_in           (sda_in),
        .timer_enable     (timer_enable),
        .load             (load),
        .shift            (shift),
        .sample           (sample),
        .load_byte        (load_byte),
        .scl_low          (scl_low),
        .sda_low          (sda_low),
        .ack              (ack),
        .nack             (nack)
    );

endmodule

// File: source/i2c_phase_timer.sv
module i2c_phase_timer (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              enable,
    input  i2c_pkg::divider_t divider,
    output logic              phase_tick,
    output i2c_pkg::phase_t   phase
);
    import i2c_pkg::*;

    divider_t cycle_count;

    // one tick per quarter bit
    assign phase_tick = (cycle_count == divider);

    // restarts while idle so the first quarter has full length
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            cycle_count <= '0;
        end else if (!enable || phase_tick) begin
            cycle_count <= '0;
        end else begin
            cycle_count <= cycle_count + 1'b1;
        end
    end

    // quarter index, wraps after four ticks
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            phase <= '0;
        end else if (!enable) begin
            phase <= '0;
        end else if (phase_tick) begin
            phase <= phase + 1'b1;
        end
    end

endmodule

// File: source/i2c_pkg.sv
`include "i2c_config.svh"

package i2c_pkg;

    typedef logic [`I2C_ADDR_WIDTH-1:0]    dev_addr_t;
    typedef logic [`I2C_BYTE_WIDTH-1:0]    reg_addr_t;
    typedef logic [`I2C_BYTE_WIDTH-1:0]    data_t;
    typedef logic [`I2C_DIVIDER_WIDTH-1:0] divider_t;

    // quarter of a bus bit
    typedef logic [1:0] phase_t;

    typedef enum logic [3:0] {
        idle,
        start,
        send_byte,
        check_ack,
        restart,
        read_byte,
        send_nack,
        stop,
        done
    } txn_state_t;

endpackage

// File: source/i2c_transaction_fsm.sv
`include "i2c_config.svh"

module i2c_transaction_fsm (
    input  logic               clock,
    input  logic               reset_n,
    input  logic               req,
    input  logic               rw,
    input  i2c_pkg::dev_addr_t device_address,
    input  i2c_pkg::reg_addr_t register_address,
    input  i2c_pkg::data_t     write_data,
    input  logic               phase_tick,
    input  i2c_pkg::phase_t    phase,
    input  logic               out_bit,
    input  logic               sda_in,
    output logic               timer_enable,
    output logic               load,
    output logic               shift,
    output logic               sample,
    output i2c_pkg::data_t     load_byte,
    output logic               scl_low,
    output logic               sda_low,
    output logic               ack,
    output logic               nack
);
    import i2c_pkg::*;

    localparam int bit_count_width = $clog2(`I2C_BITS_PER_BYTE);
    localparam logic [bit_count_width-1:0] last_bit = bit_count_width'(`I2C_BITS_PER_BYTE - 1);

    txn_state_t                 state;
    logic                       rw_q;
    dev_addr_t                  dev_q;
    reg_addr_t                  reg_q;
    data_t                      data_q;
    logic [bit_count_width-1:0] bit_count;
    logic [1:0]                 slot;
    logic [1:0]                 load_slot;
    logic                       next_is_byte;
    logic                       sda_hold;
    logic                       tick0;
    logic                       tick1;
    logic                       tick2;
    logic                       tick3;

    assign tick0 = phase_tick && (phase == 2'd0);
    assign tick1 = phase_tick && (phase == 2'd1);
    assign tick2 = phase_tick && (phase == 2'd2);
    assign tick3 = phase_tick && (phase == 2'd3);

    assign timer_enable = (state != idle) && (state != done);

    //////////////////////////////////////////////////
    // byte slot selection
    //////////////////////////////////////////////////

    // slots: 0 address+W, 1 register, 2 write data or address+R
    assign load_slot    = (state == start) ? slot : slot + 2'd1;
    assign next_is_byte = (slot == 2'd0) || ((slot == 2'd1) && !rw_q);

    always_comb begin
        case (load_slot)
            2'd0:    load_byte = {dev_q, 1'b0};
            2'd1:    load_byte = reg_q;
            default: load_byte = rw_q ? {dev_q, 1'b1} : data_q;
        endcase
    end

    assign load   = tick3 && ((state == start) ||
                              ((state == check_ack) && !nack && next_is_byte));
    assign shift  = tick3 && (state == send_byte);
    assign sample = tick2 && (state == read_byte);

    // data bits follow the shifter, every other state uses the held level
    assign sda_low = (state == send_byte) ? !out_bit : sda_hold;

    // request fields, captured once per transaction
    always_ff @(posedge clock) begin
        if ((state == idle) && req) begin
            rw_q   <= rw;
            dev_q  <= device_address;
            reg_q  <= register_address;
            data_q <= write_data;
        end
    end

    //////////////////////////////////////////////////
    // transaction sequencing
    //////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state     <= idle;
            slot      <= '0;
            bit_count <= '0;
            scl_low   <= 1'b0;
            sda_hold  <= 1'b0;
            ack       <= 1'b0;
            nack      <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (req) begin
                        state     <= start;
                        slot      <= '0;
                        bit_count <= '0;
                        nack      <= 1'b0;
                    end
                end
                start: begin
                    // SDA falls while SCL is high
                    if (tick1) sda_hold <= 1'b1;
                    if (tick2) scl_low <= 1'b1;
                    if (tick3) state <= send_byte;
                end
                send_byte, read_byte: begin
                    if (tick0) scl_low <= 1'b0;
                    if (tick2) scl_low <= 1'b1;
                    if (tick3) begin
                        bit_count <= bit_count + 1'b1;
                        if (bit_count == last_bit) begin
                            bit_count <= '0;
                            sda_hold  <= 1'b0;
                            if (state == send_byte) begin
                                state <= check_ack;
                            end else begin
                                state <= send_nack;
                            end
                        end
                    end
                end
                check_ack: begin
                    if (tick0) scl_low <= 1'b0;
                    if (tick2) begin
                        scl_low <= 1'b1;
                        nack    <= sda_in;
                    end
                    if (tick3) begin
                        slot <= slot + 2'd1;
                        if (nack) begin
                            state    <= stop;
                            sda_hold <= 1'b1;
                        end else if (next_is_byte) begin
                            state <= send_byte;
                        end else if (slot == 2'd1) begin
                            state <= restart;
                        end else if (rw_q) begin
                            state <= read_byte;
                        end else begin
                            state    <= stop;
                            sda_hold <= 1'b1;
                        end
                    end
                end
                restart: begin
                    // SCL up with SDA released, START follows
                    if (tick0) scl_low <= 1'b0;
                    if (tick3) state <= start;
                end
                send_nack: begin
                    if (tick0) scl_low <= 1'b0;
                    if (tick2) scl_low <= 1'b1;
                    if (tick3) begin
                        sda_hold <= 1'b1;
                        state    <= stop;
                    end
                end
                stop: begin
                    // SDA rises while SCL is high
                    if (tick0) scl_low <= 1'b0;
                    if (tick2) sda_hold <= 1'b0;
                    if (tick3) begin
                        state <= done;
                        ack   <= 1'b1;
                    end
                end
                done: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

// File: vlog.f
+incdir+source
source/i2c_pkg.sv
source/i2c_phase_timer.sv
source/i2c_byte_shifter.sv
source/i2c_transaction_fsm.sv
source/i2c_master.sv
dv/i2c_target_model.sv
dv/i2c_checker.sv
dv/tb_i2c_master.sv
